/* Bender.yml */
package:
  name: rx_ibuf

export_include_dirs:
  - include

sources:
  - src/rx_pkg.sv
  - src/ibuf_ram.sv
  - src/mac2ibuf.sv
  - src/ibuf2axis.sv
  - src/rx_regs.sv
  - src/rx_ibuf_top.sv
  - target: simulation
    files:
      - verif/rx_clk_gen.sv
      - verif/rx_ibuf_assertions.sv
      - verif/rx_ibuf_tb.sv

/* include/rx_consts.svh */
//////////////////////////////////////////////////
// rx ibuf constants
// buffer sizing, config defaults, register map
//////////////////////////////////////////////////
`ifndef RX_CONSTS_SVH
`define RX_CONSTS_SVH

`define IBUF_AW          6       // 64 qwords, small enough to overflow
`define MAX_LEN_DEFAULT  16'd256 // bytes

// register offsets
`define REG_CTRL         2'd0    // bit 0 enable
`define REG_MAXLEN       2'd1    // max frame length, bytes
`define REG_RXCNT        2'd2    // accepted frames, ro
`define REG_DROPCNT      2'd3    // dropped frames, ro

`endif

/* list.f */
+incdir+include
src/rx_pkg.sv
src/ibuf_ram.sv
src/mac2ibuf.sv
src/ibuf2axis.sv
src/rx_regs.sv
src/rx_ibuf_top.sv
verif/rx_clk_gen.sv
verif/rx_ibuf_assertions.sv
verif/rx_ibuf_tb.sv

/* src/ibuf2axis.sv */
//////////////////////////////////////////////////
// rx reader
// drains committed ibuf frames onto axi4-stream,
// length in tuser, partial strobe on the last beat
//////////////////////////////////////////////////
`default_nettype none

module ibuf2axis
    import rx_pkg::*;
(
    input  wire logic      m_axis_aclk,
    input  wire logic      m_axis_aresetp,
    output qword_t         m_axis_tdata_o,
    output strb_t          m_axis_tstrb_o,
    output logic [127:0]   m_axis_tuser_o,
    output logic           m_axis_tvalid_o,
    output logic           m_axis_tlast_o,
    input  wire logic      m_axis_tready_i,
    input  wire ibuf_ptr_t committed_prod_i,
    output ibuf_ptr_t      committed_cons_o,
    output ibuf_addr_t     rd_addr_o,
    input  wire qword_t    rd_data_i
);

    rd_state_e   state;
    ibuf_ptr_t   rd_ptr;     // address being presented to the ram
    ibuf_ptr_t   cons_q;     // base of the frame in flight
    flen_t       len;
    strb_t       last_strb;
    logic [13:0] qw_len;     // beats in frame
    logic [13:0] qw_snt;     // beat currently on the bus
    qword_t      ahead;      // read-ahead word while stalled
    logic [2:0]  len_lo;

    assign rd_addr_o        = ibuf_addr_t'(rd_ptr);
    assign committed_cons_o = cons_q;
    assign len_lo           = rd_data_i[34:32];

    //////////////////////////////////////////////////
    // send fsm
    //////////////////////////////////////////////////
    // in stream: rd_data holds beat+1, rd_ptr points at beat+2
    always_ff @(posedge m_axis_aclk or posedge m_axis_aresetp) begin
        if (m_axis_aresetp) begin
            state           <= rd_init;
            rd_ptr          <= '0;
            cons_q          <= '0;
            qw_snt          <= '0;
            m_axis_tvalid_o <= 1'b0;
            m_axis_tlast_o  <= 1'b0;
        end else begin
            case (state)
                rd_init: begin
                    rd_ptr <= '0;
                    cons_q <= '0;
                    state  <= rd_wait_desc;
                end
                rd_wait_desc: begin
                    if (committed_prod_i != cons_q) begin // descriptor read this cycle
                        rd_ptr <= rd_ptr + 1'b1;
                        state  <= rd_decode;
                    end
                end
                rd_decode: begin
                    len       <= rd_data_i[47:32];
                    qw_len    <= {1'b0, rd_data_i[47:35]} + (|len_lo); // round up
                    last_strb <= (len_lo == 3'd0) ? 8'hFF : strb_t'(~(8'hFF << len_lo));
                    rd_ptr    <= rd_ptr + 1'b1;
                    state     <= rd_first;
                end
                rd_first: begin
                    m_axis_tdata_o  <= rd_data_i;
                    m_axis_tuser_o  <= {112'd0, len};
                    m_axis_tvalid_o <= 1'b1;
                    qw_snt          <= 14'd1;
                    if (qw_len == 14'd1) begin        // single beat frame
                        m_axis_tstrb_o <= last_strb;
                        m_axis_tlast_o <= 1'b1;
                        state          <= rd_last;
                    end else begin
                        m_axis_tstrb_o <= 8'hFF;
                        m_axis_tlast_o <= 1'b0;
                        rd_ptr         <= rd_ptr + 1'b1;
                        state          <= rd_stream;
                    end
                end
                rd_stream: begin
                    if (m_axis_tready_i) begin
                        m_axis_tdata_o <= rd_data_i;
                        qw_snt         <= qw_snt + 1'b1;
                        if (qw_snt + 1'b1 == qw_len) begin
                            m_axis_tstrb_o <= last_strb;
                            m_axis_tlast_o <= 1'b1;
                            state          <= rd_last; // rd_ptr sits on next base
                        end else begin
                            rd_ptr <= rd_ptr + 1'b1;
                        end
                    end else begin
                        ahead <= rd_data_i;            // park it, address held
                        state <= rd_hold;
                    end
                end
                rd_hold: begin
                    if (m_axis_tready_i) begin
                        m_axis_tdata_o <= ahead;
                        qw_snt         <= qw_snt + 1'b1;
                        if (qw_snt + 1'b1 == qw_len) begin
                            m_axis_tstrb_o <= last_strb;
                            m_axis_tlast_o <= 1'b1;
                            state          <= rd_last;
                        end else begin
                            rd_ptr <= rd_ptr + 1'b1;   // ram already shows beat+2
                            state  <= rd_stream;
                        end
                    end
                end
                rd_last: begin
                    if (m_axis_tready_i) begin
                        m_axis_tvalid_o <= 1'b0;
                        m_axis_tlast_o  <= 1'b0;
                        cons_q          <= rd_ptr;     // release the whole frame
                        state           <= rd_wait_desc;
                    end
                end
                default: state <= rd_init;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/ibuf_ram.sv */
//////////////////////////////////////////////////
// ibuf memory
// simple dual-port qword ram, registered read
//////////////////////////////////////////////////
`default_nettype none
`include "rx_consts.svh"

module ibuf_ram
    import rx_pkg::*;
(
    input  wire logic       m_axis_aclk,
    input  wire logic       wr_en_i,
    input  wire ibuf_addr_t wr_addr_i,
    input  wire qword_t     wr_data_i,
    input  wire ibuf_addr_t rd_addr_i,
    output qword_t          rd_data_o
);

    qword_t mem [2**`IBUF_AW]; // descriptors and frame data

    always_ff @(posedge m_axis_aclk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i]; // data one cycle after address
    end

endmodule

`default_nettype wire

/* src/mac2ibuf.sv */
//////////////////////////////////////////////////
// rx writer
// stores mac frames in the ibuf behind a descriptor
// slot, then commits or drops them
//////////////////////////////////////////////////
`default_nettype none
`include "rx_consts.svh"

module mac2ibuf
    import rx_pkg::*;
(
    input  wire logic      m_axis_aclk,
    input  wire logic      m_axis_aresetp,
    input  wire qword_t    rx_data_i,
    input  wire logic      rx_valid_i,
    input  wire logic      rx_last_i,
    input  wire logic [2:0] rx_bytes_i,       // 0 means 8
    input  wire rx_cfg_t   cfg_i,
    input  wire ibuf_ptr_t committed_cons_i,
    output ibuf_ptr_t      committed_prod_o,
    output logic           wr_en_o,
    output ibuf_addr_t     wr_addr_o,
    output qword_t         wr_data_o,
    output logic           frame_ok_o,
    output logic           frame_drop_o
);

    wr_state_e   state;
    ibuf_ptr_t   prod_q;      // committed, also base of the open frame
    ibuf_ptr_t   wr_ptr;      // next data slot
    ibuf_ptr_t   cur_ptr;
    ibuf_ptr_t   room_diff;
    flen_t       byte_len;    // running tally
    logic [16:0] len_sum;     // one spare bit against wrap
    logic [3:0]  word_bytes;
    logic        word_fits;
    logic        store_word;
    logic        ok_q;        // descriptor cycle
    logic        drop_q;

    // first word goes right after the descriptor slot
    assign cur_ptr    = (state == wr_idle) ? prod_q + 1'b1 : wr_ptr;
    assign word_bytes = (rx_last_i && rx_bytes_i != 3'd0) ? {1'b0, rx_bytes_i} : 4'd8;
    assign len_sum    = ((state == wr_idle) ? 17'd0 : {1'b0, byte_len}) + word_bytes;
    assign room_diff  = cur_ptr - committed_cons_i; // 2**AW here means full
    assign word_fits  = !room_diff[`IBUF_AW] && (len_sum <= {1'b0, cfg_i.max_len});

    // write port is busy with the descriptor while ok_q is high,
    // so a frame starting then is lost
    assign store_word = rx_valid_i && !ok_q && word_fits &&
                        (state == wr_store || (state == wr_idle && cfg_i.enable));

    assign wr_en_o   = ok_q || store_word;
    assign wr_addr_o = ok_q ? ibuf_addr_t'(prod_q) : ibuf_addr_t'(cur_ptr);
    assign wr_data_o = ok_q ? {16'd0, byte_len, 32'd0} : rx_data_i; // len in 47:32

    assign committed_prod_o = prod_q;
    assign frame_ok_o       = ok_q;
    assign frame_drop_o     = drop_q;

    //////////////////////////////////////////////////
    // frame fsm
    //////////////////////////////////////////////////
    always_ff @(posedge m_axis_aclk or posedge m_axis_aresetp) begin
        if (m_axis_aresetp) begin
            state    <= wr_idle;
            prod_q   <= '0;
            wr_ptr   <= '0;
            byte_len <= '0;
            ok_q     <= 1'b0;
            drop_q   <= 1'b0;
        end else begin
            ok_q   <= 1'b0;
            drop_q <= 1'b0;
            if (ok_q) begin
                prod_q <= wr_ptr;                 // publish descriptor + data
            end
            case (state)
                wr_idle, wr_store: begin
                    if (rx_valid_i) begin
                        if (store_word) begin
                            wr_ptr   <= cur_ptr + 1'b1;
                            byte_len <= len_sum[15:0];
                            state    <= rx_last_i ? wr_idle : wr_store;
                            ok_q     <= rx_last_i;
                        end else begin
                            wr_ptr <= prod_q;     // rewind to base
                            state  <= rx_last_i ? wr_idle : wr_drain_drop;
                            drop_q <= rx_last_i;
                        end
                    end
                end
                wr_drain_drop: begin
                    if (rx_valid_i && rx_last_i) begin // swallow the rest
                        drop_q <= 1'b1;
                        state  <= wr_idle;
                    end
                end
                default: state <= wr_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/rx_ibuf_top.sv */
//////////////////////////////////////////////////
// rx ibuf top
// writer, ibuf, reader and registers
//////////////////////////////////////////////////
`default_nettype none

module rx_ibuf_top
    import rx_pkg::*;
(
    input  wire logic       m_axis_aclk,
    input  wire logic       m_axis_aresetp,
    // mac side
    input  wire qword_t     rx_data_i,
    input  wire logic       rx_valid_i,
    input  wire logic       rx_last_i,
    input  wire logic [2:0] rx_bytes_i,
    // register port
    input  wire logic       cfg_wr_i,
    input  wire logic       cfg_rd_i,
    input  wire reg_addr_t  cfg_addr_i,
    input  wire cnt_t       cfg_wdata_i,
    output cnt_t            cfg_rdata_o,
    // axis
    output qword_t          m_axis_tdata_o,
    output strb_t           m_axis_tstrb_o,
    output logic [127:0]    m_axis_tuser_o,
    output logic            m_axis_tvalid_o,
    output logic            m_axis_tlast_o,
    input  wire logic       m_axis_tready_i
);

    logic       wr_en;
    ibuf_addr_t wr_addr, rd_addr;
    qword_t     wr_data, rd_data;
    ibuf_ptr_t  committed_prod, committed_cons;
    rx_cfg_t    cfg;
    logic       frame_ok, frame_drop;

    mac2ibuf u_mac2ibuf (
        .m_axis_aclk, .m_axis_aresetp, .rx_data_i, .rx_valid_i, .rx_last_i, .rx_bytes_i,
        .cfg_i(cfg), .committed_cons_i(committed_cons), .committed_prod_o(committed_prod),
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
        .frame_ok_o(frame_ok), .frame_drop_o(frame_drop)
    );

    ibuf_ram u_ibuf_ram (
        .m_axis_aclk, .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .rd_addr_i(rd_addr), .rd_data_o(rd_data)
    );

    ibuf2axis u_ibuf2axis (
        .m_axis_aclk, .m_axis_aresetp, .m_axis_tdata_o, .m_axis_tstrb_o, .m_axis_tuser_o,
        .m_axis_tvalid_o, .m_axis_tlast_o, .m_axis_tready_i,
        .committed_prod_i(committed_prod), .committed_cons_o(committed_cons),
        .rd_addr_o(rd_addr), .rd_data_i(rd_data)
    );

    rx_regs u_rx_regs (
        .m_axis_aclk, .m_axis_aresetp, .cfg_wr_i, .cfg_rd_i, .cfg_addr_i, .cfg_wdata_i,
        .cfg_rdata_o, .frame_ok_i(frame_ok), .frame_drop_i(frame_drop), .cfg_o(cfg)
    );

endmodule

`default_nettype wire

/* src/rx_pkg.sv */
//////////////////////////////////////////////////
// rx ibuf package
// shared widths, config struct, fsm encodings
//////////////////////////////////////////////////
`default_nettype none
`include "rx_consts.svh"

package rx_pkg;

    typedef logic [63:0]          qword_t;     // ibuf and stream word
    typedef logic [7:0]           strb_t;      // byte strobe
    typedef logic [`IBUF_AW-1:0]  ibuf_addr_t; // memory index
    typedef logic [`IBUF_AW:0]    ibuf_ptr_t;  // index plus wrap bit
    typedef logic [15:0]          flen_t;      // frame length, bytes
    typedef logic [31:0]          cnt_t;       // stats counter
    typedef logic [1:0]           reg_addr_t;  // register offset

    typedef struct packed {
        logic  enable;
        flen_t max_len;
    } rx_cfg_t;

    typedef enum logic [1:0] {wr_idle, wr_store, wr_drain_drop} wr_state_e;

    typedef enum logic [2:0] {
        rd_init, rd_wait_desc, rd_decode, rd_first, rd_stream, rd_hold, rd_last
    } rd_state_e;

endpackage

`default_nettype wire

/* src/rx_regs.sv */
//////////////////////////////////////////////////
// rx registers
// enable, max length, accept and drop counters
//////////////////////////////////////////////////
`default_nettype none
`include "rx_consts.svh"

module rx_regs
    import rx_pkg::*;
(
    input  wire logic      m_axis_aclk,
    input  wire logic      m_axis_aresetp,
    input  wire logic      cfg_wr_i,
    input  wire logic      cfg_rd_i,
    input  wire reg_addr_t cfg_addr_i,
    input  wire cnt_t      cfg_wdata_i,
    output cnt_t           cfg_rdata_o,
    input  wire logic      frame_ok_i,
    input  wire logic      frame_drop_i,
    output rx_cfg_t        cfg_o
);

    cnt_t rx_cnt;   // accepted frames
    cnt_t drop_cnt; // dropped frames

    always_ff @(posedge m_axis_aclk or posedge m_axis_aresetp) begin
        if (m_axis_aresetp) begin
            cfg_o.enable  <= 1'b1;
            cfg_o.max_len <= `MAX_LEN_DEFAULT;
            rx_cnt        <= '0;
            drop_cnt      <= '0;
            cfg_rdata_o   <= '0;
        end else begin
            if (cfg_wr_i && cfg_addr_i == `REG_CTRL) cfg_o.enable <= cfg_wdata_i[0];
            if (cfg_wr_i && cfg_addr_i == `REG_MAXLEN) cfg_o.max_len <= cfg_wdata_i[15:0];
            if (frame_ok_i && rx_cnt != '1) rx_cnt <= rx_cnt + 1'b1;       // saturate
            if (frame_drop_i && drop_cnt != '1) drop_cnt <= drop_cnt + 1'b1;
            if (cfg_rd_i) begin
                case (cfg_addr_i)
                    `REG_CTRL:    cfg_rdata_o <= {31'd0, cfg_o.enable};
                    `REG_MAXLEN:  cfg_rdata_o <= {16'd0, cfg_o.max_len};
                    `REG_RXCNT:   cfg_rdata_o <= rx_cnt;
                    `REG_DROPCNT: cfg_rdata_o <= drop_cnt;
                    default:      cfg_rdata_o <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* verif/rx_clk_gen.sv */
//////////////////////////////////////////////////
// testbench clock and reset
// 8 ns clock, reset held 16 cycles
//////////////////////////////////////////////////
`default_nettype none

module rx_clk_gen (
    output logic m_axis_aclk_o,
    output logic m_axis_aresetp_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        m_axis_aclk_o = 1'b0;
        forever #4 m_axis_aclk_o = ~m_axis_aclk_o; // 8 ns period
    end

    initial begin
        m_axis_aresetp_o = 1'b1;
        repeat (16) @(posedge m_axis_aclk_o);
        #1 m_axis_aresetp_o = 1'b0; // off the edge
    end

endmodule

`default_nettype wire

/* verif/rx_ibuf_assertions.sv */
//////////////////////////////////////////////////
// reader checks
// stream hold rules, reset state, pointer order
//////////////////////////////////////////////////
`default_nettype none
`include "rx_consts.svh"

module rx_ibuf_assertions
    import rx_pkg::*;
(
    input wire logic      m_axis_aclk,
    input wire logic      m_axis_aresetp,
    input wire logic      tvalid_i,
    input wire logic      tready_i,
    input wire qword_t    tdata_i,
    input wire logic      tlast_i,
    input wire ibuf_ptr_t prod_i,
    input wire ibuf_ptr_t cons_i
);
    timeunit 1ns;
    timeprecision 100ps;

    ibuf_ptr_t   fill;         // committed words not yet released
    int unsigned fail_cnt = 0; // failed checks so far

    assign fill = prod_i - cons_i;

    // stalled beat must not move
    hold_beat: assert property (@(posedge m_axis_aclk) disable iff (m_axis_aresetp)
        (tvalid_i && !tready_i) |=> (tvalid_i && $stable(tdata_i) && $stable(tlast_i)))
        else begin
            $error("stream beat changed while stalled");
            fail_cnt++;
        end

    reset_idle: assert property (@(posedge m_axis_aclk) m_axis_aresetp |-> !tvalid_i)
        else begin
            $error("tvalid high during reset");
            fail_cnt++;
        end

    // a wrap distance above 2**AW means cons ran past prod
    cons_order: assert property (@(posedge m_axis_aclk) disable iff (m_axis_aresetp)
        fill <= ibuf_ptr_t'(2**`IBUF_AW))
        else begin
            $error("committed_cons passed committed_prod");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* verif/rx_ibuf_tb.sv */
//////////////////////////////////////////////////
// rx ibuf testbench
// trace driven frames, lcg payload, stream scoreboard
//////////////////////////////////////////////////
`default_nettype none
`include "rx_consts.svh"

module rx_ibuf_tb
    import rx_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk, rst;
    qword_t rx_data;
    logic rx_valid, rx_last;
    logic [2:0] rx_bytes;
    logic cfg_wr, cfg_rd;
    reg_addr_t cfg_addr;
    cnt_t cfg_wdata, cfg_rdata;
    qword_t tdata;
    strb_t tstrb;
    logic [127:0] tuser;
    logic tvalid, tlast, tready;

    qword_t exp_data[$];   // scoreboard words
    flen_t  exp_len[$];    // one entry per accepted frame
    int     beat_idx = 0;
    int     errors = 0;
    int     cycles = 0;
    int     limit = 0;     // 0 until trace is read
    logic [31:0] lcg_state = 32'ha626;
    logic [7:0]  ready_pat = 8'hFF;
    logic [2:0]  phase = '0;
    logic        drain_mode = 1'b0;

    rx_clk_gen u_clk_gen (.m_axis_aclk_o(clk), .m_axis_aresetp_o(rst));

    rx_ibuf_top uut (
        .m_axis_aclk(clk), .m_axis_aresetp(rst),
        .rx_data_i(rx_data), .rx_valid_i(rx_valid), .rx_last_i(rx_last),
        .rx_bytes_i(rx_bytes), .cfg_wr_i(cfg_wr), .cfg_rd_i(cfg_rd),
        .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata), .cfg_rdata_o(cfg_rdata),
        .m_axis_tdata_o(tdata), .m_axis_tstrb_o(tstrb), .m_axis_tuser_o(tuser),
        .m_axis_tvalid_o(tvalid), .m_axis_tlast_o(tlast), .m_axis_tready_i(tready)
    );

    bind ibuf2axis rx_ibuf_assertions u_checks (
        .m_axis_aclk, .m_axis_aresetp, .tvalid_i(m_axis_tvalid_o),
        .tready_i(m_axis_tready_i), .tdata_i(m_axis_tdata_o), .tlast_i(m_axis_tlast_o),
        .prod_i(committed_prod_i), .cons_i(committed_cons_o)
    );

    initial begin
        rx_data   = '0;
        rx_valid  = 1'b0;
        rx_last   = 1'b0;
        rx_bytes  = '0;
        cfg_wr    = 1'b0;
        cfg_rd    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        tready    = 1'b1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////
    task automatic check_qword(input string name, input qword_t got, input qword_t exp);
        if (got !== exp) stop_with_failure($sformatf(
            "** Error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_strb(input string name, input strb_t got, input strb_t exp);
        if (got !== exp) stop_with_failure($sformatf(
            "** Error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_flen(input string name, input flen_t got, input flen_t exp);
        if (got !== exp) stop_with_failure($sformatf(
            "** Error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
        if (got !== exp) stop_with_failure($sformatf(
            "** Error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) stop_with_failure($sformatf(
            "** Error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // one cycle, then next tready from the pattern
    task automatic tick();
        @(posedge clk);
        #1;
        tready = drain_mode ? 1'b1 : ready_pat[phase];
        phase  = phase + 1'b1;
    endtask

    ////////////////////////////////////////////////
    // stream monitor
    ////////////////////////////////////////////////
    always @(posedge clk) begin
        flen_t len;
        int nbeats;
        logic is_last;
        strb_t exp_strb;
        if (!rst && tvalid && tready) begin
            if (exp_len.size() == 0 || exp_data.size() == 0)
                stop_with_failure("stream beat arrived with no frame expected");
            len      = exp_len[0];
            nbeats   = (len + 7) / 8;
            beat_idx = beat_idx + 1;
            is_last  = (beat_idx == nbeats);
            exp_strb = (is_last && len[2:0] != 3'd0) ? strb_t'((9'd1 << len[2:0]) - 1) : 8'hFF;
            check_qword("m_axis_tdata", tdata, exp_data.pop_front());
            check_strb("m_axis_tstrb", tstrb, exp_strb);
            check_flen("m_axis_tuser", tuser[15:0], len);
            check_flag("m_axis_tlast", tlast, is_last);
            if (is_last) begin
                void'(exp_len.pop_front());
                beat_idx = 0;
            end
        end
    end

    // watchdog, plus bound assertion failures
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit)
            stop_with_failure("timeout, the stream did not finish in time");
        if (uut.u_ibuf2axis.u_checks.fail_cnt != 0)
            stop_with_failure("a bound stream assertion failed");
    end

    task automatic reg_write(input reg_addr_t addr, input cnt_t data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        tick();
        cfg_wr = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output cnt_t data);
        cfg_rd   = 1'b1;
        cfg_addr = addr;
        tick();
        cfg_rd = 1'b0;
        data   = cfg_rdata; // registered one cycle after the strobe
    endtask

    // empty the stream with tready forced high
    task automatic drain_stream();
        drain_mode = 1'b1;
        while (exp_data.size() != 0) tick();
        repeat (2) tick();
        drain_mode = 1'b0;
    endtask

    task automatic send_frame(input int len, input bit accept);
        int nwords;
        qword_t w;
        nwords = (len + 7) / 8;
        if (accept) exp_len.push_back(flen_t'(len));
        for (int i = 0; i < nwords; i++) begin
            lcg_state = lcg_next(lcg_state);
            w[63:32]  = lcg_state;
            lcg_state = lcg_next(lcg_state);
            w[31:0]   = lcg_state;
            if (i == nwords - 1 && len % 8 != 0)
                w = w & ((64'd1 << (8 * (len % 8))) - 1); // zero the unused bytes
            rx_data  = w;
            rx_valid = 1'b1;
            rx_last  = (i == nwords - 1);
            rx_bytes = 3'(len % 8);
            if (accept) exp_data.push_back(w);
            tick();
        end
        rx_valid = 1'b0;
        rx_last  = 1'b0;
    endtask

    ////////////////////////////////////////////////
    // trace run
    ////////////////////////////////////////////////
    initial begin
        int fd, n, total, n_acc, n_drop;
        string line;
        int t_len[$], t_gap[$], t_sync[$], t_wr[$], t_addr[$], t_exp[$];
        int t_data[$], t_ready[$];
        int a, b, c, d, e, f, g, h;
        cnt_t value;
        total  = 0;
        n_acc  = 0;
        n_drop = 0;
        fd = $fopen("verif/rx_trace.txt", "r");
        if (fd == 0) stop_with_failure("could not open the trace file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %h %h %d", a, b, c, d, e, f, g, h);
                if (n == 8) begin
                    t_len.push_back(a);
                    t_gap.push_back(b);
                    t_sync.push_back(c);
                    t_wr.push_back(d);
                    t_addr.push_back(e);
                    t_data.push_back(f);
                    t_ready.push_back(g);
                    t_exp.push_back(h);
                    total = total + (a + 7) / 8 + b;
                    if (h != 0) n_acc++;
                    else n_drop++;
                end
            end
        end
        $fclose(fd);
        limit = total * 4 + 500;

        @(negedge rst);
        repeat (4) tick();
        for (int i = 0; i < t_len.size(); i++) begin
            if (t_sync[i] != 0) drain_stream();
            ready_pat = 8'(t_ready[i]);
            if (t_wr[i] != 0) begin
                reg_write(reg_addr_t'(t_addr[i]), cnt_t'(t_data[i]));
                tick();
            end
            send_frame(t_len[i], t_exp[i] != 0);
            repeat (t_gap[i]) tick();
        end
        drain_stream();
        repeat (4) tick(); // let the last drop pulse land

        reg_read(`REG_RXCNT, value);
        check_cnt("rx_cnt", value, cnt_t'(n_acc));
        reg_read(`REG_DROPCNT, value);
        check_cnt("drop_cnt", value, cnt_t'(n_drop));
        if (uut.u_ibuf2axis.u_checks.fail_cnt != 0) errors++;

        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/rx_trace.txt */
# len bytes, gap idle cycles, sync (1 drains stream first), reg wr flag, reg addr, wdata hex,
# tready pattern hex (one bit per cycle), expected outcome (1 accept, 0 drop)
64 3 0 0 0 0 ff 1
1 2 0 0 0 0 ff 1
8 2 0 0 0 0 ff 1
13 4 0 0 0 0 ff 1
100 3 1 0 0 0 a5 1
37 2 0 0 0 0 6c 1
256 5 1 0 0 0 ff 1
120 3 1 1 1 64 ff 0
96 3 0 0 0 0 ff 1
40 3 0 1 1 100 ff 1
24 3 0 1 0 0 ff 0
24 3 0 1 0 1 b3 1
64 2 1 0 0 0 00 1
64 2 0 0 0 0 00 1
64 2 0 0 0 0 00 1
64 2 0 0 0 0 00 1
64 2 0 0 0 0 00 1
64 2 0 0 0 0 00 1
64 2 0 0 0 0 00 1
64 2 0 0 0 0 00 0
64 2 0 0 0 0 00 0
40 3 1 0 0 0 ff 1
